/* verilog.f */
+incdir+.
isa_pkg.sv
frontend_pkg.sv
fetch_unit.sv
decoder.sv
decode_stage.sv
phy_tag_freelist.sv
rename_stage.sv
frontend_top.sv
tb_frontend.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_frontend -o tb_frontend_sim
status=0
sim_out=$(./obj_dir/tb_frontend_sim) || status=$?
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

/* tb_frontend.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module tb_frontend import isa_pkg::*, frontend_pkg::*; ();

    localparam int ROWS = 32;
    localparam int BASE = 8;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic             out_ready = 1'b0;
    wb_req_t          dut_req;
    wb_rsp_t          mem_rsp = '0;
    renamed_pair_t    dut_out;
    release_t [1:0]   rel = '0;
    logic             out_valid;

    logic [`FETCH_LEN-1:0] rom [ROWS];
    renamed_pair_t         exp_tab [ROWS];
    logic [`INSN_LEN-1:0]  base_insn [BASE][2];
    renamed_t              base_exp [BASE][2];

    // Reference rename state
    phy_tag_t rat_model [`ARCH_REG_NUM];
    phy_tag_t free_q[$];
    phy_tag_t pending_q[$];

    logic [31:0]    lfsr = 32'h96ba;
    logic [3:0]     bits;
    int             s;
    int             checked = 0;
    int             n_req = 0;
    int             wait_left = 0;
    int             idle_cycles = 0;
    logic           mem_busy = 1'b0;
    logic           holding = 1'b0;
    logic           dry_seen = 1'b0;
    renamed_pair_t  held;
    renamed_pair_t  expected;
    release_t [1:0] rel_next;

    frontend_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (dut_req),
        .wb_rsp         (mem_rsp),
        .out            (dut_out),
        .out_ready      (out_ready),
        .commit_release (rel)
    );

    assign out_valid = dut_out.slot[0].valid || dut_out.slot[1].valid;

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pair(input renamed_pair_t got, input renamed_pair_t exp,
                              input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("[ERROR] %0t %s: got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [`ADDR_LEN-1:0] got,
                              input logic [`ADDR_LEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[ERROR] %0t fetch address: got %h, expected %h",
                                        $time, got, exp));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] cur);
        return {1'b0, cur[31:1]} ^ (cur[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output logic [3:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_reg};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op_imm};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd);
        return {20'(imm20), 5'(rd), op_lui};
    endfunction

    // Flags are wr_reg, illegal, uses_rs1, uses_rs2
    function automatic renamed_t exp_slot(input alu_op_e op, input logic [31:0] imm,
                                          input logic [3:0] f);
        renamed_t e;
        e = '0;
        e.valid = 1'b1;
        e.alu_op = op;
        e.imm = imm;
        {e.wr_reg, e.illegal, e.uses_rs1, e.uses_rs2} = f;
        return e;
    endfunction

    task automatic set_base(input int b, input logic [31:0] i1, input renamed_t e1,
                            input logic [31:0] i2, input renamed_t e2);
        base_insn[b][0] = i1;
        base_exp[b][0] = e1;
        base_insn[b][1] = i2;
        base_exp[b][1] = e2;
    endtask

    function automatic logic [`FETCH_LEN-1:0] fetch_word(input logic [`ADDR_LEN-1:0] adr);
        int idx;
        idx = int'((adr - `ENTRY_POINT) >> 3);
        if (idx >= 0 && idx < ROWS) begin
            return rom[idx];
        end
        return '0;
    endfunction

    // Sequential rename of one pair against the model state
    task automatic rename_expect(input int row, output renamed_pair_t e);
        int k;
        logic [`INSN_LEN-1:0] insn;
        e = exp_tab[row];
        for (k = 0; k < 2; k++) begin
            insn = rom[row][k*`INSN_LEN +: `INSN_LEN];
            if (e.slot[k].uses_rs1) e.slot[k].src1 = rat_model[insn[19:15]];
            if (e.slot[k].uses_rs2) e.slot[k].src2 = rat_model[insn[24:20]];
            if (e.slot[k].wr_reg) begin
                if (free_q.size() == 0) begin
                    stop_with_failure("Reference model ran out of free tags");
                end
                e.slot[k].old_dst = rat_model[insn[11:7]];
                e.slot[k].dst = free_q.pop_front();
                rat_model[insn[11:7]] = e.slot[k].dst;
                pending_q.push_back(e.slot[k].old_dst);
            end
        end
    endtask

    initial begin
        set_base(0, r_type(0, 3, 2, 0, 1), exp_slot(alu_add, 32'h0, 4'b1011),
                 r_type(32, 5, 1, 0, 4), exp_slot(alu_sub, 32'h0, 4'b1011));
        set_base(1, i_type(-5, 0, 0, 6), exp_slot(alu_add, 32'hffff_fffb, 4'b1010),
                 i_type(100, 6, 2, 6), exp_slot(alu_slt, 32'd100, 4'b1010));
        set_base(2, u_type(20'habcde, 7), exp_slot(alu_add, 32'habcd_e000, 4'b1000),
                 i_type(12'h403, 7, 5, 8), exp_slot(alu_sra, 32'h403, 4'b1010));
        set_base(3, r_type(0, 2, 1, 0, 0), exp_slot(alu_add, 32'h0, 4'b0011),
                 r_type(0, 11, 10, 7, 9), exp_slot(alu_and, 32'h0, 4'b1011));
        // lw x5, 0(x1) is outside the decoded subset
        set_base(4, 32'h0000_a283, exp_slot(alu_add, 32'h0, 4'b0100),
                 r_type(0, 14, 13, 3, 12), exp_slot(alu_sltu, 32'h0, 4'b1011));
        set_base(5, i_type(-1, 12, 4, 13), exp_slot(alu_xor, 32'hffff_ffff, 4'b1010),
                 r_type(0, 12, 13, 5, 14), exp_slot(alu_srl, 32'h0, 4'b1011));
        set_base(6, r_type(0, 17, 16, 6, 15), exp_slot(alu_or, 32'h0, 4'b1011),
                 i_type(31, 15, 1, 16), exp_slot(alu_sll, 32'd31, 4'b1010));
        set_base(7, i_type(12'h7ff, 0, 7, 17), exp_slot(alu_and, 32'h7ff, 4'b1010),
                 i_type(12'h800, 17, 6, 1), exp_slot(alu_or, 32'hffff_f800, 4'b1010));
        for (int r = 0; r < ROWS; r++) begin
            rom[r] = {base_insn[r % BASE][1], base_insn[r % BASE][0]};
            exp_tab[r].slot[0] = base_exp[r % BASE][0];
            exp_tab[r].slot[1] = base_exp[r % BASE][1];
            exp_tab[r].pc = `ENTRY_POINT + 32'(8 * r);
        end
        for (int r = 0; r < `ARCH_REG_NUM; r++) begin
            rat_model[r] = phy_tag_t'(r);
        end
        for (int t = 0; t < `FREE_TAG_NUM; t++) begin
            free_q.push_back(phy_tag_t'(`PHY_REG_NUM - `FREE_TAG_NUM + t));
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            // Wishbone memory with random wait states
            if (mem_rsp.ack) begin
                mem_rsp.ack <= 1'b0;
            end else if (dut_req.cyc && dut_req.stb) begin
                if (!mem_busy) begin
                    check_addr(dut_req.adr, `ENTRY_POINT + 32'(8 * n_req));
                    n_req++;
                    draw_bits(2, bits);
                    wait_left = int'(bits[1:0]);
                    mem_busy = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_rsp.ack <= 1'b1;
                    mem_rsp.dat <= fetch_word(dut_req.adr);
                    mem_busy = 1'b0;
                end else begin
                    wait_left--;
                end
            end

            if (holding) check_pair(dut_out, held, "output changed while stalled");
            if (out_valid && out_ready) begin
                rename_expect(checked, expected);
                check_pair(dut_out, expected, $sformatf("pair %0d", checked));
                checked++;
            end
            holding = out_valid && !out_ready;
            held = dut_out;

            // Long silence at the output means the free list is empty
            idle_cycles = out_valid ? 0 : idle_cycles + 1;
            if (!dry_seen && idle_cycles == 32) begin
                if (free_q.size() >= 2) begin
                    stop_with_failure("Output stalled although free tags were left");
                end
                dry_seen = 1'b1;
            end

            draw_bits(2, bits);
            out_ready <= (bits[1:0] != 2'b00);
            for (s = 0; s < 2; s++) begin
                rel_next[s] = '0;
                if (dry_seen && pending_q.size() > 0) begin
                    draw_bits(1, bits);
                    if (bits[0]) begin
                        rel_next[s].valid = 1'b1;
                        rel_next[s].tag = pending_q.pop_front();
                        free_q.push_back(rel_next[s].tag);
                    end
                end
            end
            rel <= rel_next;

            if (checked == ROWS) begin
                if (dry_seen) begin
                    $display("*** TEST PASSED ***");
                    $finish;
                end else begin
                    stop_with_failure("The free list never ran dry");
                end
            end
        end
    end

    initial begin
        repeat (8 + ROWS * 40) @(posedge clk);
        stop_with_failure($sformatf("Timeout with %0d of %0d pairs checked", checked, ROWS));
    end

endmodule

`default_nettype wire

/* frontend_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module frontend_top
    import isa_pkg::*;
    import frontend_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    output wb_req_t               wb_req,
    input  wire wb_rsp_t          wb_rsp,
    output renamed_pair_t         out,
    input  wire                   out_ready,
    input  wire release_t [1:0]   commit_release
);

    logic                  fetch_valid;
    logic [`ADDR_LEN-1:0]  fetch_pc;
    logic [`FETCH_LEN-1:0] fetch_data;
    logic                  decode_ready;
    logic                  dec_valid;
    logic [`ADDR_LEN-1:0]  dec_pc;
    decoded_t [1:0]        dec;
    logic                  rename_ready;

    fetch_unit fetch_i (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_data   (fetch_data),
        .decode_ready (decode_ready)
    );

    decode_stage decode_i (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_data   (fetch_data),
        .decode_ready (decode_ready),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec          (dec),
        .rename_ready (rename_ready)
    );

    rename_stage rename_i (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec            (dec),
        .rename_ready   (rename_ready),
        .out            (out),
        .out_ready      (out_ready),
        .commit_release (commit_release)
    );

endmodule

`default_nettype wire

/* rename_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module rename_stage
    import isa_pkg::*;
    import frontend_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   dec_valid,
    input  wire [`ADDR_LEN-1:0]   dec_pc,
    input  wire decoded_t [1:0]   dec,
    output logic                  rename_ready,
    output renamed_pair_t         out,
    input  wire                   out_ready,
    input  wire release_t [1:0]   commit_release
);

    phy_tag_t       rat [`ARCH_REG_NUM];
    phy_tag_t [1:0] alloc_tag;
    phy_tag_t [1:0] map_rs1;
    phy_tag_t [1:0] map_rs2;
    phy_tag_t [1:0] map_rd;
    renamed_pair_t  nxt;
    logic [1:0]     alloc;
    logic           allocatable;
    logic           out_valid;
    logic           load;

    assign out_valid    = out.slot[0].valid || out.slot[1].valid;
    assign rename_ready = allocatable && !(out_valid && !out_ready);
    assign load         = dec_valid && rename_ready;
    assign alloc[0]     = load && dec[0].wr_reg;
    assign alloc[1]     = load && dec[1].wr_reg;

    phy_tag_freelist freelist_i (
        .clk            (clk),
        .reset          (reset),
        .alloc          (alloc),
        .alloc_tag      (alloc_tag),
        .allocatable    (allocatable),
        .commit_release (commit_release)
    );

    always_comb begin
        map_rs1[0] = rat[dec[0].rs1];
        map_rs2[0] = rat[dec[0].rs2];
        map_rd[0]  = rat[dec[0].rd];
        // Slot 2 sees the tag slot 1 writes in the same pair
        map_rs1[1] = (dec[0].wr_reg && dec[1].rs1 == dec[0].rd) ? alloc_tag[0] : rat[dec[1].rs1];
        map_rs2[1] = (dec[0].wr_reg && dec[1].rs2 == dec[0].rd) ? alloc_tag[0] : rat[dec[1].rs2];
        map_rd[1]  = (dec[0].wr_reg && dec[1].rd == dec[0].rd) ? alloc_tag[0] : rat[dec[1].rd];
    end

    always_comb begin
        nxt.pc = dec_pc;
        for (int i = 0; i < 2; i++) begin
            nxt.slot[i].valid    = 1'b1;
            nxt.slot[i].alu_op   = dec[i].alu_op;
            nxt.slot[i].imm      = dec[i].imm;
            nxt.slot[i].wr_reg   = dec[i].wr_reg;
            nxt.slot[i].illegal  = dec[i].illegal;
            nxt.slot[i].uses_rs1 = dec[i].uses_rs1;
            nxt.slot[i].uses_rs2 = dec[i].uses_rs2;
            nxt.slot[i].src1     = dec[i].uses_rs1 ? map_rs1[i] : '0;
            nxt.slot[i].src2     = dec[i].uses_rs2 ? map_rs2[i] : '0;
            nxt.slot[i].dst      = dec[i].wr_reg ? alloc_tag[i] : '0;
            nxt.slot[i].old_dst  = dec[i].wr_reg ? map_rd[i] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `ARCH_REG_NUM; r++) begin
                rat[r] <= phy_tag_t'(r);
            end
        end else if (load) begin
            if (dec[0].wr_reg) rat[dec[0].rd] <= alloc_tag[0];
            // Later writer wins on a shared rd
            if (dec[1].wr_reg) rat[dec[1].rd] <= alloc_tag[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out.slot[0].valid <= 1'b0;
            out.slot[1].valid <= 1'b0;
        end else if (load) begin
            out <= nxt;
        end else if (out_ready) begin
            out.slot[0].valid <= 1'b0;
            out.slot[1].valid <= 1'b0;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out));

endmodule

`default_nettype wire

/* phy_tag_freelist.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module phy_tag_freelist import frontend_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire [1:0]             alloc,
    output phy_tag_t [1:0]        alloc_tag,
    output logic                  allocatable,
    input  wire release_t [1:0]   commit_release
);

    localparam int PTR_W = $clog2(`FREE_TAG_NUM);
    localparam int CNT_W = PTR_W + 1;

    phy_tag_t         fifo [`FREE_TAG_NUM];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_pop;
    logic [1:0]       n_push;

    assign n_pop  = 2'(alloc[0]) + 2'(alloc[1]);
    assign n_push = 2'(commit_release[0].valid) + 2'(commit_release[1].valid);

    assign alloc_tag[0] = fifo[head];
    // slot 2 gets the head itself when slot 1 takes nothing
    assign alloc_tag[1] = alloc[0] ? fifo[head + PTR_W'(1)] : fifo[head];

    assign allocatable = (count >= CNT_W'(2));

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(`FREE_TAG_NUM);
            // Upper half of the tag space starts out free
            for (int i = 0; i < `FREE_TAG_NUM; i++) begin
                fifo[i] <= phy_tag_t'(`PHY_REG_NUM - `FREE_TAG_NUM + i);
            end
        end else begin
            head  <= head + PTR_W'(n_pop);
            tail  <= tail + PTR_W'(n_push);
            count <= count + CNT_W'(n_push) - CNT_W'(n_pop);
            if (commit_release[0].valid) begin
                fifo[tail] <= commit_release[0].tag;
            end
            if (commit_release[1].valid) begin
                fifo[tail + PTR_W'(commit_release[0].valid)] <= commit_release[1].tag;
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(`FREE_TAG_NUM));

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module decode_stage import isa_pkg::*; (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fetch_valid,
    input  wire [`ADDR_LEN-1:0]   fetch_pc,
    input  wire [`FETCH_LEN-1:0]  fetch_data,
    output logic                  decode_ready,
    output logic                  dec_valid,
    output logic [`ADDR_LEN-1:0]  dec_pc,
    output decoded_t [1:0]        dec,
    input  wire                   rename_ready
);

    decoded_t [1:0] dec_next;

    // Lower word is slot 1
    for (genvar i = 0; i < 2; i++) begin : g_dec
        decoder decoder_i (
            .insn (fetch_data[i*`INSN_LEN +: `INSN_LEN]),
            .dec  (dec_next[i])
        );
    end

    assign decode_ready = !dec_valid || rename_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (decode_ready) begin
            dec_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_ready && fetch_valid) begin
            dec    <= dec_next;
            dec_pc <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

/* decoder.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module decoder import isa_pkg::*; (
    input  wire [`INSN_LEN-1:0] insn,
    output decoded_t            dec
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(insn[6:0]);
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    always_comb begin
        dec        = '0;
        dec.rd     = insn[11:7];
        dec.rs1    = insn[19:15];
        dec.rs2    = insn[24:20];
        dec.alu_op = alu_add;
        case (opcode)
            op_reg: begin
                dec.alu_op   = alu_sel(funct3, funct7[5]);
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                // only SUB and SRA take the alternate funct7
                dec.illegal  = (funct7 != 7'b0000000) &&
                    !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            op_imm: begin
                dec.alu_op   = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
                dec.uses_rs1 = 1'b1;
                dec.imm      = {{20{insn[31]}}, insn[31:20]};
            end
            op_lui:  dec.imm = {insn[31:12], 12'b0};
            default: dec.illegal = 1'b1;
        endcase
        dec.wr_reg = !dec.illegal && (dec.rd != '0);
        if (dec.illegal) begin
            dec.uses_rs1 = 1'b0;
            dec.uses_rs2 = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "frontend_consts.svh"

module fetch_unit import frontend_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    output wb_req_t                wb_req,
    input  wire wb_rsp_t           wb_rsp,
    output logic                   fetch_valid,
    output logic [`ADDR_LEN-1:0]   fetch_pc,
    output logic [`FETCH_LEN-1:0]  fetch_data,
    input  wire                    decode_ready
);

    typedef enum logic {
        FETCH_IDLE,
        FETCH_BUS
    } fetch_state_e;

    fetch_state_e          state;
    logic [`ADDR_LEN-1:0]  pc;
    logic                  buf_valid;
    logic [`FETCH_LEN-1:0] buf_data;
    logic [`ADDR_LEN-1:0]  buf_pc;
    logic                  ack;
    logic                  take;
    logic                  start;

    assign ack   = (state == FETCH_BUS) && wb_rsp.ack;
    assign take  = fetch_valid && decode_ready;
    // Next request waits for an empty or draining buffer
    assign start = (state == FETCH_IDLE) && (!buf_valid || take);

    assign wb_req.cyc = (state == FETCH_BUS);
    assign wb_req.stb = (state == FETCH_BUS);
    assign wb_req.adr = pc;

    // Returned word bypasses the buffer when decode takes it at once
    assign fetch_valid = buf_valid || ack;
    assign fetch_pc    = buf_valid ? buf_pc : pc;
    assign fetch_data  = buf_valid ? buf_data : wb_rsp.dat;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH_IDLE;
            pc        <= `ENTRY_POINT;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: if (start) state <= FETCH_BUS;
                FETCH_BUS:  if (wb_rsp.ack) state <= FETCH_IDLE;
                default:    state <= FETCH_IDLE;
            endcase
            if (ack) pc <= pc + `ADDR_LEN'(8);
            if (ack && !decode_ready) buf_valid <= 1'b1;
            else if (take) buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ack && !decode_ready) begin
            buf_data <= wb_rsp.dat;
            buf_pc   <= pc;
        end
    end

    a_drop_after_ack: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && wb_rsp.ack |=> !wb_req.cyc && !wb_req.stb);

    a_adr_hold: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

`default_nettype wire

/* frontend_pkg.sv */
`default_nettype none

`include "frontend_consts.svh"

package frontend_pkg;

    import isa_pkg::*;

    typedef logic [`PHY_REG_SEL-1:0] phy_tag_t;

    // Wishbone classic, read only
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic [`ADDR_LEN-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`FETCH_LEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                 valid;
        alu_op_e              alu_op;
        logic [`DATA_LEN-1:0] imm;
        logic                 wr_reg;
        logic                 illegal;
        logic                 uses_rs1;
        logic                 uses_rs2;
        phy_tag_t             src1;
        phy_tag_t             src2;
        phy_tag_t             dst;
        phy_tag_t             old_dst;
    } renamed_t;

    // Index 0 is slot 1, the lower instruction
    typedef struct packed {
        renamed_t [1:0]       slot;
        logic [`ADDR_LEN-1:0] pc;
    } renamed_pair_t;

    typedef struct packed {
        logic     valid;
        phy_tag_t tag;
    } release_t;

endpackage

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

`include "frontend_consts.svh"

package isa_pkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [`REG_SEL-1:0]  rd;
        logic [`REG_SEL-1:0]  rs1;
        logic [`REG_SEL-1:0]  rs2;
        logic                 uses_rs1;
        logic                 uses_rs2;
        logic                 wr_reg;
        logic                 illegal;
        alu_op_e              alu_op;
        logic [`DATA_LEN-1:0] imm;
    } decoded_t;

endpackage

`default_nettype wire

/* frontend_consts.svh */
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

`define INSN_LEN     32
`define FETCH_LEN    64
`define ADDR_LEN     32
`define DATA_LEN     32

`define ARCH_REG_NUM 32
`define REG_SEL      5
`define PHY_REG_NUM  64
`define PHY_REG_SEL  6
`define FREE_TAG_NUM 32

`define ENTRY_POINT  32'h0000_0200

`endif
